// ==== test/cpu_tests.txt ====
# test <name> | prog <word index hex> <word hex> | load <word index hex> <word hex>
# expect <register decimal> <value hex>; load words are written while the core runs
test bytes_move
prog 0 1134
prog 1 2112
prog 2 3c12
prog 3 0001
expect 1 1234
expect 2 1234
expect 15 0008
test arith_flags
prog 0 1100
prog 1 2180
prog 2 1201
prog 3 2280
prog 4 15aa
prog 5 2500
prog 6 8312
prog 7 9421
prog 8 f512
prog 9 0001
expect 3 0001
expect 4 0001
expect 5 00aa
expect 14 0015
test logic_carry
prog 0 11ff
prog 1 21ff
prog 2 1201
prog 3 2200
prog 4 8312
prog 5 a422
prog 6 f021
prog 7 b512
prog 8 c615
prog 9 e712
prog a d824
prog b 0001
expect 3 0000
expect 4 0003
expect 5 fffd
expect 6 fffd
expect 7 fffe
expect 8 0003
expect 14 0018
test memory
prog 0 1100
prog 1 2101
prog 2 12ef
prog 3 22be
prog 4 3221
prog 5 3031
prog 6 1401
prog 7 2401
prog 8 1500
prog 9 2555
prog a 3454
prog b 0001
expect 2 beef
expect 3 beef
expect 5 55be
test countdown
prog 0 1103
prog 1 2100
prog 2 1201
prog 3 2200
prog 4 1314
prog 5 2300
prog 6 161c
prog 7 2600
prog 8 15aa
prog 9 2500
prog a 9112
prog b 0313
prog c 0306
prog d 15bb
prog e 0001
expect 1 0000
expect 5 00aa
expect 14 0012
expect 15 001e
test load_while_running
prog 0 1100
prog 1 2102
prog 2 1207
prog 3 2200
prog 4 8322
prog 5 3041
prog 6 8543
prog 7 0001
load 100 c0de
load 101 1234
expect 3 000e
expect 4 c0de
expect 5 c0ec
expect 15 0010

// ==== files.f ====
source/cpu_pkg.sv
source/mem_bus_if.sv
source/alu.sv
source/reg_file.sv
source/cpu_core.sv
source/word_memory.sv
source/cpu_top.sv
test/cpu_properties.sv
test/cpu_checker.sv
test/tb_cpu.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cpu -f files.f
out=$(./obj_dir/Vtb_cpu) || true
echo "$out"
grep -qx "all tests passed" <<< "$out"

// ==== test/tb_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

   logic        clk;
   logic        reset;
   logic        start;
   logic        prog_we;
   logic [11:0] prog_addr;
   word_t       prog_data;
   reg_num_t    dbg_reg;
   logic        halted;
   word_t       dbg_data;

   string test_names[$];
   int    prog_t[$];
   int    prog_a[$];
   int    prog_d[$];
   int    load_t[$];            // words written while the core runs
   int    load_a[$];
   int    load_d[$];
   int    exp_t[$];
   int    exp_r[$];
   int    exp_v[$];
   int    cycle_count;
   int    cycle_limit;

   cpu_top u_dut (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .dbg_reg   (dbg_reg),
      .halted    (halted),
      .dbg_data  (dbg_data)
   );

   cpu_checker u_checker (
      .clk      (clk),
      .halted   (halted),
      .dbg_data (dbg_data),
      .dbg_reg  (dbg_reg)
   );

   bind cpu_core cpu_properties u_props (
      .clk       (clk),
      .reset     (reset),
      .req_valid (bus.req_valid),
      .req_ready (bus.req_ready),
      .cmd       (bus.cmd),
      .addr      (bus.addr),
      .wr_data   (bus.wr_data),
      .rsp_valid (bus.rsp_valid),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("core never halted within %0d cycles", cycle_limit);
         $display("tests failed");
         $finish;
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic read_tests();
      int    fd;
      int    n;
      int    a;
      int    d;
      string line;
      string kw;
      string name;
      fd = $fopen("test/cpu_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open test/cpu_tests.txt");
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         kw = "";
         if (n > 0)
            n = $sscanf(line, "%s", kw);
         if (n < 1 || kw.substr(0, 0) == "#")
            continue;
         if (kw == "test") begin
            n = $sscanf(line, "%s %s", kw, name);
            test_names.push_back(name);
         end else if (kw == "prog") begin
            n = $sscanf(line, "%s %h %h", kw, a, d);
            prog_t.push_back(test_names.size() - 1);
            prog_a.push_back(a);
            prog_d.push_back(d);
         end else if (kw == "load") begin
            n = $sscanf(line, "%s %h %h", kw, a, d);
            load_t.push_back(test_names.size() - 1);
            load_a.push_back(a);
            load_d.push_back(d);
         end else if (kw == "expect") begin
            n = $sscanf(line, "%s %d %h", kw, a, d);
            exp_t.push_back(test_names.size() - 1);
            exp_r.push_back(a);
            exp_v.push_back(d);
         end else begin
            $display("unknown line in test file: %s", kw);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_test(input int t);
      u_checker.begin_test(test_names[t]);
      reset = 1'b1;
      repeat (2) next_cycle();
      reset = 1'b0;
      for (int i = 0; i < prog_t.size(); i++) begin
         if (prog_t[i] == t) begin
            prog_we   = 1'b1;
            prog_addr = 12'(prog_a[i]);
            prog_data = word_t'(prog_d[i]);
            next_cycle();
         end
      end
      prog_we = 1'b0;
      next_cycle();
      start = 1'b1;
      next_cycle();
      start = 1'b0;
      for (int i = 0; i < load_t.size(); i++) begin
         if (load_t[i] == t) begin
            prog_we   = 1'b1;
            prog_addr = 12'(load_a[i]);
            prog_data = word_t'(load_d[i]);
            next_cycle();
         end
      end
      prog_we = 1'b0;
      u_checker.wait_halted();
      for (int i = 0; i < exp_t.size(); i++) begin
         if (exp_t[i] == t)
            u_checker.check_reg(exp_r[i], exp_v[i]);
      end
      u_checker.end_test();
      next_cycle();
   endtask

   initial begin
      reset       = 1'b1;
      start       = 1'b0;
      prog_we     = 1'b0;
      prog_addr   = '0;
      prog_data   = '0;
      cycle_count = 0;
      cycle_limit = 0;
      read_tests();
      cycle_limit = 200 * (prog_t.size() + load_t.size());
      if (test_names.size() == 0) begin
         $display("no tests were read");
         $display("tests failed");
      end else begin
         for (int t = 0; t < test_names.size(); t++)
            run_test(t);
         u_checker.report();
         if (u_checker.tests_failed == 0 && u_checker.tests_run == test_names.size() &&
             u_dut.u_core.u_props.fail_count == 0)
            $display("all tests passed");
         else
            $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/cpu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_checker import cpu_pkg::*; (
   input  logic     clk,
   input  logic     halted,
   input  word_t    dbg_data,
   output reg_num_t dbg_reg
);

   int    tests_run;
   int    tests_failed;
   int    errors;
   int    test_errors;
   string test_name;

   initial begin
      dbg_reg      = '0;
      tests_run    = 0;
      tests_failed = 0;
      errors       = 0;
      test_errors  = 0;
   end

   function automatic string reg_name(input int num);
      if (num == 15)
         return "pc";
      else if (num == 14)
         return "flags";
      return $sformatf("r%0d", num);
   endfunction

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic wait_halted();
      while (!halted) begin
         @(posedge clk);
         #1;
      end
   endtask

   // drive the index after the edge, sample mid cycle
   task automatic check_reg(input int num, input int expected);
      @(posedge clk);
      #1 dbg_reg = reg_num_t'(num);
      #4;
      if (dbg_data !== word_t'(expected)) begin
         $display("Fail %0t %s: got %h expected %h", $time, reg_name(num), dbg_data,
                  word_t'(expected));
         test_errors++;
         errors++;
      end
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors != 0) begin
         tests_failed++;
         $display("test %s: FAIL, %0d wrong registers", test_name, test_errors);
      end else begin
         $display("test %s: ok", test_name);
      end
   endtask

   task automatic report();
      $display("%0d tests run, %0d failed, %0d register errors", tests_run, tests_failed,
               errors);
   endtask

endmodule

`default_nettype wire

// ==== test/cpu_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_properties import cpu_pkg::*; (
   input logic     clk,
   input logic     reset,
   input logic     req_valid,
   input logic     req_ready,
   input bus_cmd_e cmd,
   input word_t    addr,
   input word_t    wr_data,
   input logic     rsp_valid,
   input logic     halted
);

   int fail_count = 0;

   // a stalled request keeps every field until it transfers
   req_stable: assert property (@(posedge clk) disable iff (reset)
      req_valid && !req_ready |=> req_valid && $stable(cmd) && $stable(addr) &&
                                  $stable(wr_data))
      else begin
         fail_count++;
         $error("request changed while stalled");
      end

   rsp_follows: assert property (@(posedge clk) disable iff (reset)
      req_valid && req_ready |=> rsp_valid)
      else begin
         fail_count++;
         $error("no response one cycle after an accepted request");
      end

   halt_sticky: assert property (@(posedge clk) disable iff (reset)
      halted |=> halted)
      else begin
         fail_count++;
         $error("halted fell without reset");
      end

   halt_quiet: assert property (@(posedge clk) disable iff (reset)
      halted |-> !req_valid)
      else begin
         fail_count++;
         $error("request issued while halted");
      end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        start,
   input  logic        prog_we,
   input  logic [11:0] prog_addr,   // word index
   input  word_t       prog_data,
   input  reg_num_t    dbg_reg,
   output logic        halted,
   output word_t       dbg_data
);

   mem_bus_if u_bus (.clk(clk));

   cpu_core u_core (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .bus      (u_bus.core),
      .halted   (halted),
      .dbg_reg  (dbg_reg),
      .dbg_data (dbg_data)
   );

   word_memory u_mem (
      .clk       (clk),
      .bus       (u_bus.mem),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data)
   );

endmodule

`default_nettype wire

// ==== source/word_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_memory import cpu_pkg::*; (
   input  logic        clk,
   mem_bus_if.mem      bus,
   input  logic        prog_we,
   input  logic [11:0] prog_addr,
   input  word_t       prog_data
);

   word_t                        mem [mem_words];
   logic [addr_width-1:0]        byte_addr;
   logic [$clog2(mem_words)-1:0] idx;
   logic                         accept;

   assign byte_addr     = bus.addr;
   assign idx           = byte_addr[$clog2(mem_words):1];   // bit 0 picks the byte
   assign bus.req_ready = !prog_we;                 // program load has priority
   assign accept        = bus.req_valid && bus.req_ready;

   always_ff @(posedge clk) begin
      bus.rsp_valid <= accept;
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end else if (accept) begin
         case (bus.cmd)
            cmd_read_w: bus.rd_data <= mem[idx];
            cmd_write_w: mem[idx] <= bus.wr_data;
            cmd_read_b: begin
               if (byte_addr[0])
                  bus.rd_data <= {8'h00, mem[idx][15:8]};
               else
                  bus.rd_data <= {8'h00, mem[idx][7:0]};
            end
            cmd_write_b: begin
               if (byte_addr[0])
                  mem[idx][15:8] <= bus.wr_data[7:0];
               else
                  mem[idx][7:0] <= bus.wr_data[7:0];
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     start,
   mem_bus_if.core  bus,
   output logic     halted,
   input  reg_num_t dbg_reg,
   output word_t    dbg_data
);

   core_state_e state;
   core_state_e state_next;
   word_t       ir;
   word_t       pc_plus2;     // latched while the fetch is issued
   word_t       flag_q;       // flag word as seen outside execute
   logic        req_valid;
   bus_cmd_e    req_cmd;
   word_t       req_addr;
   word_t       req_wr_data;  // also the high byte for byte loads
   reg_num_t    rd_a;
   reg_num_t    rd_b;
   word_t       data_a;
   word_t       data_b;
   logic        rf_we;
   reg_num_t    rf_wr_num;
   word_t       rf_wr_data;
   logic        pc_we;
   word_t       pc_next;
   logic        flag_we;
   word_t       flag_next;
   word_t       alu_result;
   logic [3:0]  alu_flags;
   logic        fetch_issue;
   logic        bus_go;

   assign bus.req_valid = req_valid;
   assign bus.cmd       = req_cmd;
   assign bus.addr      = req_addr;
   assign bus.wr_data   = req_wr_data;
   assign halted        = flag_q[flag_halt];
   assign fetch_issue   = (state == st_fetch) && !req_valid && !bus.rsp_valid;

   // pc and flags on the read ports outside execute
   always_comb begin
      if (state == st_exec) begin
         rd_a = (ir[15:12] == 4'h1 || ir[15:12] == 4'h2) ? ir[11:8] : ir[7:4];
         rd_b = ir[3:0];
      end else begin
         rd_a = reg_pc;
         rd_b = reg_flag;
      end
   end

   always_comb begin
      state_next = state;
      rf_we      = 1'b0;
      rf_wr_num  = ir[7:4];
      rf_wr_data = data_a;
      pc_we      = 1'b0;
      pc_next    = pc_plus2;
      flag_we    = 1'b0;
      flag_next  = flag_q;
      bus_go     = 1'b0;
      case (state)
         st_idle: if (start && !data_b[flag_halt]) state_next = st_fetch;
         st_fetch: if (bus.rsp_valid) state_next = st_exec;
         st_exec: begin
            pc_we      = 1'b1;
            state_next = st_fetch;
            casez (ir)
               16'h0001: begin                        // HALT
                  flag_we              = 1'b1;
                  flag_next[flag_halt] = 1'b1;
                  state_next           = st_idle;
               end
               16'b0000_0001_1110_????: pc_next = data_b;  // JP R
               16'b0000_0011_0???_????: begin         // JPN f / JP f
                  if (flag_q[ir[5:4]] == ir[6])
                     pc_next = data_b;
               end
               16'b0001_????_????_????: begin         // low byte immediate
                  rf_we      = 1'b1;
                  rf_wr_num  = ir[11:8];
                  rf_wr_data = {data_a[15:8], ir[7:0]};
               end
               16'b0010_????_????_????: begin         // high byte immediate
                  rf_we      = 1'b1;
                  rf_wr_num  = ir[11:8];
                  rf_wr_data = {ir[7:0], data_a[7:0]};
               end
               16'b0011_0??0_????_????: begin         // memory command on A at (B)
                  bus_go     = 1'b1;
                  state_next = st_bus;
               end
               16'b0011_110?_????_????: begin         // A to B
                  rf_we     = 1'b1;
                  rf_wr_num = ir[3:0];
               end
               16'b0011_111?_????_????: begin         // B to A
                  rf_we      = 1'b1;
                  rf_wr_data = data_b;
               end
               16'b1???_????_????_????: begin         // D = A op B
                  rf_we          = (alu_op_e'(ir[15:12]) != op_cp);
                  rf_wr_num      = ir[11:8];
                  rf_wr_data     = alu_result;
                  flag_we        = 1'b1;
                  flag_next[3:0] = alu_flags;
               end
               default: ;                             // NOP and unknown encodings
            endcase
         end
         st_bus: begin
            if (bus.rsp_valid) begin
               state_next = st_fetch;
               rf_we      = (req_cmd == cmd_read_w) || (req_cmd == cmd_read_b);
               rf_wr_data = (req_cmd == cmd_read_b) ?
                            {req_wr_data[15:8], bus.rd_data[7:0]} : bus.rd_data;
            end
         end
         default: state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         req_valid <= 1'b0;
         flag_q    <= '0;
      end else begin
         state <= state_next;
         if (fetch_issue || bus_go)
            req_valid <= 1'b1;
         else if (req_valid && bus.req_ready)
            req_valid <= 1'b0;
         if (state != st_exec)
            flag_q <= data_b;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_issue) begin
         req_cmd  <= cmd_read_w;
         req_addr <= data_a;
         pc_plus2 <= data_a + word_t'(2);
      end
      if (bus_go) begin
         req_cmd     <= bus_cmd_e'(ir[11:9]);
         req_addr    <= data_b;
         req_wr_data <= data_a;
      end
      if (state == st_fetch && bus.rsp_valid)
         ir <= bus.rd_data;
   end

   reg_file u_reg_file (
      .clk       (clk),
      .reset     (reset),
      .rd_a      (rd_a),
      .rd_b      (rd_b),
      .data_a    (data_a),
      .data_b    (data_b),
      .we        (rf_we),
      .wr_num    (rf_wr_num),
      .wr_data   (rf_wr_data),
      .pc_we     (pc_we),
      .pc_next   (pc_next),
      .flag_we   (flag_we),
      .flag_next (flag_next),
      .dbg_reg   (dbg_reg),
      .dbg_data  (dbg_data)
   );

   alu u_alu (
      .op        (alu_op_e'(ir[15:12])),
      .a         (data_a),
      .b         (data_b),
      .carry_in  (flag_q[flag_carry]),
      .result    (alu_result),
      .flags_out (alu_flags)
   );

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file import cpu_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  reg_num_t rd_a,
   input  reg_num_t rd_b,
   output word_t    data_a,
   output word_t    data_b,
   input  logic     we,
   input  reg_num_t wr_num,
   input  word_t    wr_data,
   input  logic     pc_we,
   input  word_t    pc_next,
   input  logic     flag_we,
   input  word_t    flag_next,
   input  reg_num_t dbg_reg,
   output word_t    dbg_data
);

   word_t regs [16];

   always_ff @(posedge clk) begin
      if (reset) begin
         regs[reg_pc]   <= '0;
         regs[reg_flag] <= '0;
      end else begin
         if (pc_we)
            regs[reg_pc] <= pc_next;
         if (flag_we)
            regs[reg_flag] <= flag_next;
         if (we)
            regs[wr_num] <= wr_data;   // last, wins over pc and flag ports
      end
   end

   assign data_a   = regs[rd_a];
   assign data_b   = regs[rd_b];
   assign dbg_data = regs[dbg_reg];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu import cpu_pkg::*; (
   input  alu_op_e    op,
   input  word_t      a,
   input  word_t      b,
   input  logic       carry_in,
   output word_t      result,
   output logic [3:0] flags_out
);

   logic [data_width:0] a_x;
   logic [data_width:0] b_x;
   logic [data_width:0] cin_x;
   logic [data_width:0] res;
   logic                is_add;
   logic                is_logic;

   always_comb begin
      a_x      = {1'b0, a};
      b_x      = {1'b0, b};
      cin_x    = {{data_width{1'b0}}, carry_in};
      is_add   = 1'b0;
      is_logic = 1'b0;
      case (op)
         op_add: begin
            res    = a_x + b_x;
            is_add = 1'b1;
         end
         op_adc: begin
            res    = a_x + b_x + cin_x;
            is_add = 1'b1;
         end
         op_sub, op_cp: res = a_x - b_x;     // bit 16 is the borrow
         op_sbc: res = a_x - b_x - cin_x;
         op_and: begin
            res      = a_x & b_x;
            is_logic = 1'b1;
         end
         op_or: begin
            res      = a_x | b_x;
            is_logic = 1'b1;
         end
         op_xor: begin
            res      = a_x ^ b_x;
            is_logic = 1'b1;
         end
         default: res = '0;
      endcase

      result                   = res[data_width-1:0];
      flags_out[flag_sign]     = res[data_width-1];
      flags_out[flag_zero]     = (res[data_width-1:0] == '0);
      if (is_logic) begin
         flags_out[flag_carry]    = 1'b0;
         flags_out[flag_overflow] = ~^res[data_width-1:0];   // even parity
      end else if (is_add) begin
         flags_out[flag_carry]    = res[data_width];
         flags_out[flag_overflow] = (a[data_width-1] == b[data_width-1]) &&
                                    (res[data_width-1] != a[data_width-1]);
      end else begin
         flags_out[flag_carry]    = res[data_width];
         flags_out[flag_overflow] = (a[data_width-1] != b[data_width-1]) &&
                                    (res[data_width-1] != a[data_width-1]);
      end
   end

endmodule

`default_nettype wire

// ==== source/mem_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if import cpu_pkg::*; (input logic clk);

   logic     req_valid;
   logic     req_ready;
   bus_cmd_e cmd;
   word_t    addr;                            // byte address
   word_t    wr_data;
   logic     rsp_valid;                       // one cycle after acceptance
   word_t    rd_data;

   modport core (input clk, req_ready, rsp_valid, rd_data,
                 output req_valid, cmd, addr, wr_data);

   modport mem (input clk, req_valid, cmd, addr, wr_data,
                output req_ready, rsp_valid, rd_data);

endinterface

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   localparam int data_width = 16;
   localparam int addr_width = 16;           // byte address
   localparam int mem_words  = 4096;

   typedef logic [data_width-1:0] word_t;
   typedef logic [3:0]            reg_num_t;

   localparam reg_num_t reg_pc   = 4'd15;
   localparam reg_num_t reg_flag = 4'd14;

   // flag word bit positions, 0 to 3 selectable by a condition field
   localparam int flag_carry    = 0;
   localparam int flag_zero     = 1;
   localparam int flag_sign     = 2;
   localparam int flag_overflow = 3;
   localparam int flag_halt     = 4;

   typedef enum logic [2:0] {
      cmd_read_w  = 3'd0,
      cmd_write_w = 3'd1,
      cmd_read_b  = 3'd2,
      cmd_write_b = 3'd3
   } bus_cmd_e;

   // top nibble of the three-register group
   typedef enum logic [3:0] {
      op_add = 4'h8,
      op_sub = 4'h9,
      op_adc = 4'ha,
      op_sbc = 4'hb,
      op_and = 4'hc,
      op_or  = 4'hd,
      op_xor = 4'he,
      op_cp  = 4'hf
   } alu_op_e;

   typedef enum logic [1:0] {st_idle, st_fetch, st_exec, st_bus} core_state_e;

endpackage

`default_nettype wire
